//--- compile.f
rtl/cornet_pkg.sv
rtl/cornet_memory.sv
rtl/cornet_bus_decode.sv
rtl/cornet_bus_unit.sv
rtl/cornet_core.sv
rtl/cornet_system.sv
tests/cornet_sva.sv
tests/cornet_tb.sv

//--- Makefile
# Verilator lint and simulation of the cornet subsystem

TOP = cornet_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "run ended early, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/cornet_tb.sv
// testbench for the cornet subsystem
// program table with expected port writes, loaded in reset and run in a loop
// watchdog, error counts and closing verdict
`timescale 1ns/1ps
`default_nettype none

module cornet_tb;

   localparam int CLK_PERIOD   = 20;
   localparam int NUM_TESTS    = 5;
   localparam int MAX_IMG      = 32;
   localparam int MAX_EXP      = 8;
   localparam int RESET_CYCLES = 16;
   localparam int IDLE_CYCLES  = 400;    // no strobe for this long ends a test
   localparam int TEST_CYCLES  = 2000;   // upper bound of one run plus idle window
   localparam int WATCHDOG_NS  = NUM_TESTS * (MAX_IMG + TEST_CYCLES) * CLK_PERIOD + 10000;

   localparam logic [15:0] PORT_ADDR  = 16'hD000;
   localparam logic [7:0]  PORT_LO    = PORT_ADDR[7:0];
   localparam logic [7:0]  PORT_HI    = PORT_ADDR[15:8];
   localparam logic [15:0] PROG_BASE  = 16'h0200;
   localparam logic [15:0] TABLE_BASE = 16'h03FC;   // crosses into page 04

   logic                    clk;
   logic                    reset_n;
   logic                    load_en;
   cornet_pkg::addr_t       load_addr;
   cornet_pkg::byte_t       load_data;
   cornet_pkg::byte_t       port_data;
   logic                    port_strobe;

   logic [15:0] img_addr [NUM_TESTS][MAX_IMG];
   logic [7:0]  img_data [NUM_TESTS][MAX_IMG];
   int          img_len  [NUM_TESTS];
   logic [7:0]  exp_val  [NUM_TESTS][MAX_EXP];
   int          exp_count[NUM_TESTS];

   logic [31:0] lcg_state = 32'h4cdb_f78a;
   int          value_errors = 0;
   int          count_errors = 0;

   cornet_system #(
      .MEM_ADDR_WIDTH (12),
      .READ_WAIT      (2)
   ) UUT (
      .clk         (clk),
      .reset_n     (reset_n),
      .load_en     (load_en),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .port_data   (port_data),
      .port_strobe (port_strobe)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired at %0t, the run did not complete", $time);
      $display("Simulation finished: FAIL");
      $finish;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // bytes listed first to last in the packed argument, right aligned
   task automatic add_bytes(input int t, input logic [15:0] start, input int n,
                            input logic [255:0] bytes);
      for (int i = 0; i < n; i++) begin
         img_addr[t][img_len[t]] = start + 16'(i);
         img_data[t][img_len[t]] = bytes[(n - 1 - i) * 8 +: 8];
         img_len[t]++;
      end
   endtask

   task automatic add_expect(input int t, input logic [7:0] value);
      exp_val[t][exp_count[t]] = value;
      exp_count[t]++;
   endtask

   // **************************************************
   // program table
   // **************************************************
   task automatic build_table();
      logic [7:0] entry;
      for (int t = 0; t < NUM_TESTS; t++) begin
         img_len[t]   = 0;
         exp_count[t] = 0;
         add_bytes(t, 16'hFFFC, 2, 256'({PROG_BASE[7:0], PROG_BASE[15:8]}));
      end
      // LDA #55, STA port, JMP self
      add_bytes(0, PROG_BASE, 8, 256'({8'hA9, 8'h55, 8'h8D, PORT_LO, PORT_HI,
                                       8'h4C, 8'h05, 8'h02}));
      add_expect(0, 8'h55);
      // LDA #3C, LDX #FB, loop INX / STA port / BNE until X wraps
      add_bytes(1, PROG_BASE, 13, 256'({8'hA9, 8'h3C, 8'hA2, 8'hFB, 8'hE8, 8'h8D,
                                        PORT_LO, PORT_HI, 8'hD0, 8'hFA,
                                        8'h4C, 8'h0A, 8'h02}));
      for (int i = 0; i < 5; i++)
         add_expect(1, 8'h3C);
      // LDX #FA, loop LDA 0302,X / STA port / INX / BNE
      add_bytes(2, PROG_BASE, 14, 256'({8'hA2, 8'hFA, 8'hBD, 8'h02, 8'h03, 8'h8D,
                                        PORT_LO, PORT_HI, 8'hE8, 8'hD0, 8'hF7,
                                        8'h4C, 8'h0B, 8'h02}));
      for (int i = 0; i < 6; i++) begin
         lcg_state = lcg_next(lcg_state);
         entry     = lcg_state[23:16];
         add_bytes(2, TABLE_BASE + 16'(i), 1, 256'(entry));
         add_expect(2, entry);
      end
      // store to 0500, overwrite A, read back with X=0
      add_bytes(3, PROG_BASE, 18, 256'({8'hA9, 8'hA7, 8'h8D, 8'h00, 8'h05,
                                        8'hA9, 8'h18, 8'hA2, 8'h00,
                                        8'hBD, 8'h00, 8'h05, 8'h8D, PORT_LO, PORT_HI,
                                        8'h4C, 8'h0F, 8'h02}));
      add_expect(3, 8'hA7);
      // undefined opcode 02 between LDA # and STA
      add_bytes(4, PROG_BASE, 9, 256'({8'hA9, 8'h6E, 8'h02, 8'h8D, PORT_LO, PORT_HI,
                                       8'h4C, 8'h06, 8'h02}));
      add_expect(4, 8'h6E);
   endtask

   task automatic check_write(input int t, input int idx);
      assert (idx < exp_count[t])
      else begin
         $display("test %0d: extra port write of %02h at %0t", t + 1, port_data, $time);
         count_errors++;
      end
      if (idx < exp_count[t]) begin
         assert (port_data === exp_val[t][idx])
         else begin
            $display("mismatch at %0t: port_data expected %02h actual %02h",
                     $time, exp_val[t][idx], port_data);
            value_errors++;
         end
      end
   endtask

   task automatic run_test(input int t);
      int load_cycles;
      int seen;
      int idle;
      load_cycles = (img_len[t] > RESET_CYCLES) ? img_len[t] : RESET_CYCLES;
      seen        = 0;
      idle        = 0;
      @(posedge clk);
      #2;
      reset_n = 1'b0;
      for (int i = 0; i < load_cycles; i++) begin
         load_en = (i < img_len[t]);
         if (i < img_len[t]) begin
            load_addr = img_addr[t][i];
            load_data = img_data[t][i];
         end
         @(posedge clk);
         #2;
      end
      load_en = 1'b0;
      reset_n = 1'b1;
      while (idle < IDLE_CYCLES) begin
         @(negedge clk);   // outputs settled
         if (port_strobe) begin
            check_write(t, seen);
            seen++;
            idle = 0;
         end else begin
            idle++;
         end
      end
      assert (seen == exp_count[t])
      else begin
         $display("test %0d: expected %0d port writes but saw %0d", t + 1, exp_count[t], seen);
         count_errors++;
      end
   endtask

   // **************************************************
   // main sequence
   // **************************************************
   initial begin
      reset_n   = 1'b0;
      load_en   = 1'b0;
      load_addr = '0;
      load_data = '0;
      build_table();
      for (int t = 0; t < NUM_TESTS; t++)
         run_test(t);
      $display("errors: %0d value mismatches, %0d write count errors, %0d bus assertion failures",
               value_errors, count_errors, UUT.u_bus_decode.bus_checks.fail_count);
      if (value_errors + count_errors + UUT.u_bus_decode.bus_checks.fail_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/cornet_sva.sv
// bus protocol checks on the cpu side of the bus decode
// read request hold, ack framing, read/write exclusion, strobe width
`timescale 1ns/1ps
`default_nettype none

module cornet_sva (
   input wire                  clk,
   input wire                  reset_n,
   input cornet_pkg::mem_req_t cpu_req,
   input wire logic            cpu_rd_ack,
   input wire logic            port_strobe
);

   int fail_count = 0;

   rd_held_until_ack: assert property (@(posedge clk) disable iff (!reset_n)
      (cpu_req.rd_req && !cpu_rd_ack) |=> (cpu_req.rd_req && $stable(cpu_req.addr)))
      else begin
         $error("rd_req dropped or address moved before rd_ack");
         fail_count++;
      end

   ack_needs_request: assert property (@(posedge clk) disable iff (!reset_n)
      cpu_rd_ack |-> cpu_req.rd_req)
      else begin
         $error("rd_ack without a pending rd_req");
         fail_count++;
      end

   no_read_with_write: assert property (@(posedge clk) disable iff (!reset_n)
      !(cpu_req.rd_req && cpu_req.wr_en))
      else begin
         $error("rd_req and wr_en high in the same cycle");
         fail_count++;
      end

   strobe_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
      port_strobe |=> !port_strobe)
      else begin
         $error("port_strobe longer than one cycle");
         fail_count++;
      end

endmodule

bind cornet_bus_decode cornet_sva bus_checks (
   .clk         (clk),
   .reset_n     (reset_n),
   .cpu_req     (cpu_req),
   .cpu_rd_ack  (cpu_rd_ack),
   .port_strobe (port_strobe)
);

`default_nettype wire

//--- rtl/cornet_system.sv
// cornet subsystem top level
// core, bus unit, bus decode and RAM
`timescale 1ns/1ps
`default_nettype none

module cornet_system #(
   parameter int MEM_ADDR_WIDTH = 12,
   parameter int READ_WAIT      = 2
) (
   input  wire                  clk,
   input  wire                  reset_n,
   input  wire logic            load_en,
   input  cornet_pkg::addr_t    load_addr,
   input  cornet_pkg::byte_t    load_data,
   output cornet_pkg::byte_t    port_data,
   output logic                 port_strobe
);

   cornet_pkg::access_req_t core_req;
   logic                    acc_done;
   cornet_pkg::addr_t       acc_rd_word;

   cornet_pkg::mem_req_t    cpu_req;
   cornet_pkg::byte_t       cpu_rd_data;
   logic                    cpu_rd_ack;

   cornet_pkg::mem_req_t    ram_req;
   cornet_pkg::byte_t       ram_rd_data;
   logic                    ram_rd_ack;

   cornet_core u_core (
      .clk         (clk),
      .reset_n     (reset_n),
      .acc_req     (core_req),
      .acc_done    (acc_done),
      .acc_rd_word (acc_rd_word)
   );

   cornet_bus_unit u_bus_unit (
      .clk         (clk),
      .reset_n     (reset_n),
      .acc_req     (core_req),
      .acc_done    (acc_done),
      .acc_rd_word (acc_rd_word),
      .mem_req     (cpu_req),
      .rd_data     (cpu_rd_data),
      .rd_ack      (cpu_rd_ack)
   );

   cornet_bus_decode u_bus_decode (
      .clk         (clk),
      .reset_n     (reset_n),
      .cpu_req     (cpu_req),
      .cpu_rd_data (cpu_rd_data),
      .cpu_rd_ack  (cpu_rd_ack),
      .ram_req     (ram_req),
      .ram_rd_data (ram_rd_data),
      .ram_rd_ack  (ram_rd_ack),
      .port_data   (port_data),
      .port_strobe (port_strobe)
   );

   cornet_memory #(
      .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
      .READ_WAIT      (READ_WAIT)
   ) u_memory (
      .clk       (clk),
      .reset_n   (reset_n),
      .mem_req   (ram_req),
      .rd_data   (ram_rd_data),
      .rd_ack    (ram_rd_ack),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_data (load_data)
   );

endmodule

`default_nettype wire

//--- rtl/cornet_core.sv
// minimal 6502 style instruction sequencer
// A, X, PC and Z registers
// LDA #, LDX #, STA abs, LDA abs,X, INX, JMP abs, BNE; others run as NOP
`timescale 1ns/1ps
`default_nettype none

module cornet_core (
   input  wire                     clk,
   input  wire                     reset_n,
   output cornet_pkg::access_req_t acc_req,
   input  wire logic               acc_done,
   input  cornet_pkg::addr_t       acc_rd_word
);

   localparam cornet_pkg::byte_t OP_LDA_IMM = 8'hA9;
   localparam cornet_pkg::byte_t OP_LDX_IMM = 8'hA2;
   localparam cornet_pkg::byte_t OP_STA_ABS = 8'h8D;
   localparam cornet_pkg::byte_t OP_LDA_ABX = 8'hBD;
   localparam cornet_pkg::byte_t OP_INX     = 8'hE8;
   localparam cornet_pkg::byte_t OP_JMP_ABS = 8'h4C;
   localparam cornet_pkg::byte_t OP_BNE     = 8'hD0;

   typedef enum logic [3:0] {
      CS_RESET,
      CS_VECTOR_WAIT,
      CS_FETCH,
      CS_FETCH_WAIT,
      CS_DECODE,
      CS_OPER_WAIT,
      CS_DATA,
      CS_DATA_WAIT,
      CS_RETIRE
   } core_state_t;

   core_state_t       state;
   cornet_pkg::addr_t pc;
   cornet_pkg::addr_t pc_next;
   cornet_pkg::addr_t seq_pc;
   cornet_pkg::addr_t oper_addr;
   cornet_pkg::addr_t branch_off;
   cornet_pkg::byte_t opcode;
   cornet_pkg::byte_t a;
   cornet_pkg::byte_t x;
   cornet_pkg::byte_t x_inc;
   logic              z;

   function automatic cornet_pkg::addr_t op_length(input cornet_pkg::byte_t op);
      case (op)
         OP_LDA_IMM, OP_LDX_IMM, OP_BNE:     op_length = 16'd2;
         OP_STA_ABS, OP_LDA_ABX, OP_JMP_ABS: op_length = 16'd3;
         default:                            op_length = 16'd1;
      endcase
   endfunction

   function automatic cornet_pkg::access_req_t make_req(
      input cornet_pkg::access_kind_t kind,
      input cornet_pkg::addr_t        addr,
      input cornet_pkg::byte_t        data
   );
      cornet_pkg::access_req_t req;
      req.kind    = kind;
      req.addr    = addr;
      req.wr_data = data;
      return req;
   endfunction

   assign seq_pc     = pc + op_length(opcode);
   assign branch_off = {{8{acc_rd_word[7]}}, acc_rd_word[7:0]};   // signed rel offset
   assign x_inc      = x + 8'd1;

   always_ff @(posedge clk) begin
      acc_req.kind <= cornet_pkg::ACC_NONE;   // one cycle request
      if (!reset_n) begin
         state   <= CS_RESET;
         pc      <= '0;
         pc_next <= '0;
         a       <= '0;
         x       <= '0;
         z       <= 1'b0;
      end else begin
         case (state)
            // ************************************************
            // reset vector and instruction fetch
            // ************************************************
            CS_RESET: begin
               acc_req <= make_req(cornet_pkg::ACC_RD_WORD, cornet_pkg::RESET_VECTOR, '0);
               state   <= CS_VECTOR_WAIT;
            end
            CS_VECTOR_WAIT:
               if (acc_done) begin
                  pc    <= acc_rd_word;
                  state <= CS_FETCH;
               end
            CS_FETCH: begin
               acc_req <= make_req(cornet_pkg::ACC_RD_BYTE, pc, '0);
               state   <= CS_FETCH_WAIT;
            end
            CS_FETCH_WAIT:
               if (acc_done) begin
                  opcode <= acc_rd_word[7:0];
                  state  <= CS_DECODE;
               end
            // ************************************************
            // decode and operand access
            // ************************************************
            CS_DECODE:
               case (opcode)
                  OP_LDA_IMM, OP_LDX_IMM: begin
                     acc_req <= make_req(cornet_pkg::ACC_RD_BYTE, pc + 16'd1, '0);
                     state   <= CS_OPER_WAIT;
                  end
                  OP_STA_ABS, OP_LDA_ABX, OP_JMP_ABS: begin
                     acc_req <= make_req(cornet_pkg::ACC_RD_WORD, pc + 16'd1, '0);
                     state   <= CS_OPER_WAIT;
                  end
                  OP_INX: begin
                     x       <= x_inc;
                     z       <= (x_inc == 8'h00);
                     pc_next <= seq_pc;
                     state   <= CS_RETIRE;
                  end
                  OP_BNE:
                     if (!z) begin
                        acc_req <= make_req(cornet_pkg::ACC_RD_BYTE, pc + 16'd1, '0);
                        state   <= CS_OPER_WAIT;
                     end else begin
                        pc_next <= seq_pc;   // not taken
                        state   <= CS_RETIRE;
                     end
                  default: begin
                     pc_next <= seq_pc;      // unknown opcode runs as one byte NOP
                     state   <= CS_RETIRE;
                  end
               endcase
            CS_OPER_WAIT:
               if (acc_done) begin
                  state   <= CS_RETIRE;
                  pc_next <= seq_pc;
                  case (opcode)
                     OP_LDA_IMM: begin
                        a <= acc_rd_word[7:0];
                        z <= (acc_rd_word[7:0] == 8'h00);
                     end
                     OP_LDX_IMM: begin
                        x <= acc_rd_word[7:0];
                        z <= (acc_rd_word[7:0] == 8'h00);
                     end
                     OP_JMP_ABS: pc_next <= acc_rd_word;
                     OP_BNE:     pc_next <= seq_pc + branch_off;
                     OP_STA_ABS: begin
                        oper_addr <= acc_rd_word;
                        state     <= CS_DATA;
                     end
                     OP_LDA_ABX: begin
                        oper_addr <= acc_rd_word + {8'h00, x};
                        state     <= CS_DATA;
                     end
                     default: ;
                  endcase
               end
            // ************************************************
            // data access of STA abs and LDA abs,X
            // ************************************************
            CS_DATA: begin
               if (opcode == OP_STA_ABS)
                  acc_req <= make_req(cornet_pkg::ACC_WR_BYTE, oper_addr, a);
               else
                  acc_req <= make_req(cornet_pkg::ACC_RD_BYTE, oper_addr, '0);
               state <= CS_DATA_WAIT;
            end
            CS_DATA_WAIT:
               if (acc_done) begin
                  if (opcode == OP_LDA_ABX) begin
                     a <= acc_rd_word[7:0];
                     z <= (acc_rd_word[7:0] == 8'h00);
                  end
                  pc_next <= seq_pc;
                  state   <= CS_RETIRE;
               end
            CS_RETIRE: begin
               pc    <= pc_next;
               state <= CS_FETCH;
            end
            default: state <= CS_RESET;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/cornet_bus_unit.sv
// bus unit between core accesses and byte bus cycles
// byte and word reads, byte writes
// word reads assembled from two bus cycles, low byte first
`timescale 1ns/1ps
`default_nettype none

module cornet_bus_unit (
   input  wire                     clk,
   input  wire                     reset_n,
   input  cornet_pkg::access_req_t acc_req,
   output logic                    acc_done,
   output cornet_pkg::addr_t       acc_rd_word,
   output cornet_pkg::mem_req_t    mem_req,
   input  cornet_pkg::byte_t       rd_data,
   input  wire logic               rd_ack
);

   typedef enum logic [2:0] {
      BU_IDLE,
      BU_BYTE,
      BU_WORD_LO,
      BU_WORD_HI,
      BU_WRITE
   } bus_state_t;

   bus_state_t state;

   always_ff @(posedge clk) begin
      acc_done      <= 1'b0;
      mem_req.wr_en <= 1'b0;   // write is a single pulse
      if (!reset_n) begin
         state          <= BU_IDLE;
         mem_req.rd_req <= 1'b0;
      end else begin
         case (state)
            BU_IDLE:
               case (acc_req.kind)
                  cornet_pkg::ACC_RD_BYTE: begin
                     mem_req.addr   <= acc_req.addr;
                     mem_req.rd_req <= 1'b1;
                     state          <= BU_BYTE;
                  end
                  cornet_pkg::ACC_RD_WORD: begin
                     mem_req.addr   <= acc_req.addr;
                     mem_req.rd_req <= 1'b1;
                     state          <= BU_WORD_LO;
                  end
                  cornet_pkg::ACC_WR_BYTE: begin
                     mem_req.addr    <= acc_req.addr;
                     mem_req.wr_data <= acc_req.wr_data;
                     mem_req.wr_en   <= 1'b1;
                     state           <= BU_WRITE;
                  end
                  default: ;
               endcase
            BU_BYTE:
               if (rd_ack) begin
                  acc_rd_word    <= {8'h00, rd_data};
                  mem_req.rd_req <= 1'b0;
                  acc_done       <= 1'b1;
                  state          <= BU_IDLE;
               end
            BU_WORD_LO:
               if (rd_ack) begin
                  acc_rd_word[7:0] <= rd_data;
                  mem_req.rd_req   <= 1'b0;   // drop for a cycle, then addr+1
                  mem_req.addr     <= mem_req.addr + 16'd1;
                  state            <= BU_WORD_HI;
               end
            BU_WORD_HI:
               if (!mem_req.rd_req) begin
                  mem_req.rd_req <= 1'b1;
               end else if (rd_ack) begin
                  acc_rd_word[15:8] <= rd_data;
                  mem_req.rd_req    <= 1'b0;
                  acc_done          <= 1'b1;
                  state             <= BU_IDLE;
               end
            BU_WRITE: begin
               acc_done <= 1'b1;   // no ack on writes
               state    <= BU_IDLE;
            end
            default: state <= BU_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/cornet_bus_decode.sv
// address decode of the byte bus
// steers cycles to RAM or to the output port
// output port register with read ack and write strobe
`timescale 1ns/1ps
`default_nettype none

module cornet_bus_decode (
   input  wire                  clk,
   input  wire                  reset_n,
   input  cornet_pkg::mem_req_t cpu_req,
   output cornet_pkg::byte_t    cpu_rd_data,
   output logic                 cpu_rd_ack,
   output cornet_pkg::mem_req_t ram_req,
   input  cornet_pkg::byte_t    ram_rd_data,
   input  wire logic            ram_rd_ack,
   output cornet_pkg::byte_t    port_data,
   output logic                 port_strobe
);

   logic port_hit;
   logic port_ack;

   assign port_hit = (cpu_req.addr == cornet_pkg::PORT_ADDR);

   always_comb begin
      ram_req        = cpu_req;
      ram_req.rd_req = cpu_req.rd_req && !port_hit;
      ram_req.wr_en  = cpu_req.wr_en && !port_hit;
   end

   // ************************************************
   // output port
   // ************************************************
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         port_data   <= '0;
         port_strobe <= 1'b0;
         port_ack    <= 1'b0;
      end else begin
         port_strobe <= cpu_req.wr_en && port_hit;
         port_ack    <= cpu_req.rd_req && port_hit && !port_ack;   // one cycle read
         if (cpu_req.wr_en && port_hit)
            port_data <= cpu_req.wr_data;
      end
   end

   assign cpu_rd_ack  = port_ack || ram_rd_ack;
   assign cpu_rd_data = port_ack ? port_data : ram_rd_data;   // port reads back last write

endmodule

`default_nettype wire

//--- rtl/cornet_memory.sv
// byte RAM on the shared bus
// read ack delayed by READ_WAIT extra cycles
// load port for program images that also works in reset
`timescale 1ns/1ps
`default_nettype none

module cornet_memory #(
   parameter int MEM_ADDR_WIDTH = 12,
   parameter int READ_WAIT      = 2
) (
   input  wire                  clk,
   input  wire                  reset_n,
   input  cornet_pkg::mem_req_t mem_req,
   output cornet_pkg::byte_t    rd_data,
   output logic                 rd_ack,
   input  wire logic            load_en,
   input  cornet_pkg::addr_t    load_addr,
   input  cornet_pkg::byte_t    load_data
);

   localparam int CNT_W = (READ_WAIT > 0) ? $clog2(READ_WAIT + 1) : 1;

   cornet_pkg::byte_t ram [2**MEM_ADDR_WIDTH];

   logic [MEM_ADDR_WIDTH-1:0] bus_idx;
   logic [MEM_ADDR_WIDTH-1:0] load_idx;
   logic [CNT_W-1:0]          wait_cnt;
   logic                      ack_due;

   assign bus_idx  = mem_req.addr[MEM_ADDR_WIDTH-1:0];   // mirrors over the map
   assign load_idx = load_addr[MEM_ADDR_WIDTH-1:0];

   // ************************************************
   // array writes
   // ************************************************
   always_ff @(posedge clk) begin
      if (load_en)
         ram[load_idx] <= load_data;
      else if (mem_req.wr_en)
         ram[bus_idx] <= mem_req.wr_data;
   end

   // ************************************************
   // read wait and ack
   // ************************************************
   assign ack_due = mem_req.rd_req && !rd_ack && (wait_cnt == CNT_W'(READ_WAIT));

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         rd_ack   <= 1'b0;
         wait_cnt <= '0;
      end else begin
         rd_ack <= ack_due;
         if (!mem_req.rd_req || rd_ack || ack_due)
            wait_cnt <= '0;
         else
            wait_cnt <= wait_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (ack_due)
         rd_data <= ram[bus_idx];
   end

endmodule

`default_nettype wire

//--- rtl/cornet_pkg.sv
// shared widths and data types for the cornet subsystem
// access kinds between core and bus unit
// bus cycle struct and address map constants
`default_nettype none

package cornet_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  byte_t;

   // ************************************************
   // core to bus unit access
   // ************************************************
   typedef enum logic [1:0] {
      ACC_NONE,
      ACC_RD_BYTE,
      ACC_RD_WORD,    // two bytes in little endian order
      ACC_WR_BYTE
   } access_kind_t;

   typedef struct packed {
      access_kind_t kind;
      addr_t        addr;
      byte_t        wr_data;
   } access_req_t;

   // ************************************************
   // byte bus cycle
   // ************************************************
   typedef struct packed {
      addr_t addr;
      byte_t wr_data;
      logic  rd_req;     // level, held until rd_ack
      logic  wr_en;      // single cycle pulse
   } mem_req_t;

   localparam addr_t RESET_VECTOR = 16'hFFFC;
   localparam addr_t PORT_ADDR    = 16'hD000;   // output port

endpackage

`default_nettype wire
